/* verilog/udp_net_pkg.sv */
package udp_net_pkg;

  // Ethernet II framing
  localparam logic [15:0] eth_type_ipv4 = 16'h0800;

  // Address width in bits
  localparam int mac_w = 48;

  // IPv4 header without options, ID and TOS stay zero
  localparam logic [7:0]  ip_ver_ihl    = 8'h45;
  localparam logic [15:0] ip_flags_frag = 16'h4000;
  localparam logic [7:0]  ip_ttl        = 8'hff;
  localparam logic [7:0]  ip_proto_udp  = 8'h11;

  // IPv4 header length in bytes
  localparam int ip_hdr_bytes = 20;

  // Address width in bits
  localparam int ip_w = 32;

  // UDP header, checksum always sent as zero
  localparam int udp_hdr_bytes = 8;

  // Port width in bits
  localparam int port_w = 16;

  // 14 + 20 + 8 header bytes, the first 40 fill whole lane words
  localparam int hdr_words = 5;

endpackage

/* verilog/udp_tx_pkg.sv */
package udp_tx_pkg;

  // MAC lane
  localparam int data_w = 64;
  localparam logic [7:0] lane_all  = 8'hff;
  localparam logic [7:0] lane_last = 8'h03;

  // Payload queue
  localparam int data_depth = 256;
  localparam int data_aw    = $clog2(data_depth);
  localparam int data_afull = 240;

  // Frame record queue
  localparam int rec_depth = 16;
  localparam int rec_aw    = $clog2(rec_depth);
  localparam int rec_afull = 14;

  // Next-hop table
  localparam int arp_entries = 256;
  localparam int arp_aw      = $clog2(arp_entries);

  // Word counts and header lengths
  localparam int len_w = 16;

  // Framer sequence
  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_hdr,
    tx_first,
    tx_data,
    tx_last
  } tx_state_t;

endpackage

/* verilog/udp_tx_ingress.sv */
`timescale 1ns/1ps

module udp_tx_ingress (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           app_tx_valid,
  input  logic                           app_tx_end_of_frame,
  input  logic [udp_tx_pkg::data_w-1:0]  app_tx_data,
  input  logic [udp_net_pkg::ip_w-1:0]   app_tx_dest_ip,
  input  logic [udp_net_pkg::port_w-1:0] app_tx_dest_port,
  input  logic                           pay_pop,
  input  logic                           rec_pop,
  output logic [udp_tx_pkg::data_w-1:0]  pay_data,
  output logic [udp_net_pkg::ip_w-1:0]   rec_ip,
  output logic [udp_net_pkg::port_w-1:0] rec_port,
  output logic [udp_tx_pkg::len_w-1:0]   rec_words,
  output logic                           rec_empty,
  output logic                           app_tx_afull,
  output logic                           app_tx_overflow
);
  import udp_net_pkg::*;
  import udp_tx_pkg::*;

  logic [data_w-1:0]  data_mem [data_depth];
  logic [data_aw-1:0] data_wr_ptr;
  logic [data_aw-1:0] data_rd_ptr;
  logic [data_aw:0]   data_cnt;
  logic               data_full;
  logic               data_wr;
  logic               data_rd;

  logic [ip_w-1:0]    rec_ip_mem [rec_depth];
  logic [port_w-1:0]  rec_port_mem [rec_depth];
  logic [len_w-1:0]   rec_words_mem [rec_depth];
  logic [rec_aw-1:0]  rec_wr_ptr;
  logic [rec_aw-1:0]  rec_rd_ptr;
  logic [rec_aw:0]    rec_cnt;
  logic               rec_full;
  logic               rec_wr;
  logic               rec_rd;

  // Words seen so far in the current frame, counting the word on the bus
  logic [len_w-1:0]   word_cnt;

  assign data_full = data_cnt == (data_aw + 1)'(data_depth);
  assign data_wr   = app_tx_valid && !data_full;
  assign data_rd   = pay_pop && (data_cnt != '0);

  assign rec_full  = rec_cnt == (rec_aw + 1)'(rec_depth);
  assign rec_empty = rec_cnt == '0;
  assign rec_wr    = app_tx_valid && app_tx_end_of_frame && !rec_full;
  assign rec_rd    = rec_pop && !rec_empty;

  // Show-ahead heads of both queues
  assign pay_data  = data_mem[data_rd_ptr];
  assign rec_ip    = rec_ip_mem[rec_rd_ptr];
  assign rec_port  = rec_port_mem[rec_rd_ptr];
  assign rec_words = rec_words_mem[rec_rd_ptr];

  assign app_tx_afull = (data_cnt >= (data_aw + 1)'(data_afull)) ||
                        (rec_cnt >= (rec_aw + 1)'(rec_afull));

  always_ff @(posedge mac_clk) begin
    if (data_wr) begin
      data_mem[data_wr_ptr] <= app_tx_data;
    end
    if (rec_wr) begin
      rec_ip_mem[rec_wr_ptr]    <= app_tx_dest_ip;
      rec_port_mem[rec_wr_ptr]  <= app_tx_dest_port;
      rec_words_mem[rec_wr_ptr] <= word_cnt;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      data_wr_ptr     <= '0;
      data_rd_ptr     <= '0;
      data_cnt        <= '0;
      rec_wr_ptr      <= '0;
      rec_rd_ptr      <= '0;
      rec_cnt         <= '0;
      word_cnt        <= len_w'(1);
      app_tx_overflow <= 1'b0;
    end else begin
      if (data_wr) begin
        data_wr_ptr <= data_wr_ptr + 1'b1;
      end
      if (data_rd) begin
        data_rd_ptr <= data_rd_ptr + 1'b1;
      end
      if (data_wr && !data_rd) begin
        data_cnt <= data_cnt + 1'b1;
      end else if (!data_wr && data_rd) begin
        data_cnt <= data_cnt - 1'b1;
      end

      if (rec_wr) begin
        rec_wr_ptr <= rec_wr_ptr + 1'b1;
      end
      if (rec_rd) begin
        rec_rd_ptr <= rec_rd_ptr + 1'b1;
      end
      if (rec_wr && !rec_rd) begin
        rec_cnt <= rec_cnt + 1'b1;
      end else if (!rec_wr && rec_rd) begin
        rec_cnt <= rec_cnt - 1'b1;
      end

      // Restart at one so the end-of-frame word is already counted
      if (app_tx_valid) begin
        word_cnt <= app_tx_end_of_frame ? len_w'(1) : word_cnt + 1'b1;
      end

      // Sticky until reset
      if (app_tx_valid && (data_full || (app_tx_end_of_frame && rec_full))) begin
        app_tx_overflow <= 1'b1;
      end
    end
  end

endmodule

/* verilog/udp_tx_route.sv */
`timescale 1ns/1ps

module udp_tx_route (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic [udp_net_pkg::ip_w-1:0]   local_ip,
  input  logic [udp_tx_pkg::arp_aw-1:0]  local_gateway,
  input  logic                           arp_wr_en,
  input  logic [udp_tx_pkg::arp_aw-1:0]  arp_wr_addr,
  input  logic [udp_net_pkg::mac_w-1:0]  arp_wr_mac,
  input  logic [udp_net_pkg::ip_w-1:0]   rec_ip,
  input  logic [udp_net_pkg::port_w-1:0] rec_port,
  input  logic [udp_tx_pkg::len_w-1:0]   rec_words,
  input  logic                           rec_empty,
  input  logic                           hop_ack,
  output logic                           rec_pop,
  output logic                           hop_req,
  output logic [udp_net_pkg::mac_w-1:0]  hop_mac,
  output logic [udp_net_pkg::ip_w-1:0]   hop_ip,
  output logic [udp_net_pkg::port_w-1:0] hop_port,
  output logic [udp_tx_pkg::len_w-1:0]   hop_words,
  output logic [udp_tx_pkg::len_w-1:0]   hop_ip_len,
  output logic [udp_tx_pkg::len_w-1:0]   hop_udp_len,
  output logic [15:0]                    hop_csum
);
  import udp_net_pkg::*;
  import udp_tx_pkg::*;

  logic [mac_w-1:0]  arp_mem [arp_entries];
  logic [arp_aw-1:0] arp_idx;
  logic [2:0]        stage_vld;
  logic              ack_wait;
  logic              busy;
  logic [18:0]       fixed_raw;
  logic [16:0]       fixed_fold;
  logic [15:0]       fixed_sum;
  logic [17:0]       csum_0;
  logic [16:0]       csum_1;

  // Same subnet goes straight to the host, everything else to the gateway
  assign arp_idx = (rec_ip[ip_w-1:8] == local_ip[ip_w-1:8]) ? rec_ip[arp_aw-1:0] : local_gateway;

  // Header words that never change per frame, checksum field taken as zero
  assign fixed_raw = 19'({ip_ver_ihl, 8'h00}) + 19'(ip_flags_frag) +
                     19'({ip_ttl, ip_proto_udp}) +
                     19'(local_ip[31:16]) + 19'(local_ip[15:0]);
  assign fixed_fold = 17'(fixed_raw[15:0]) + 17'(fixed_raw[18:16]);

  assign busy    = (stage_vld != '0) || hop_req || ack_wait;
  assign rec_pop = !busy && !rec_empty;

  always_ff @(posedge mac_clk) begin
    if (arp_wr_en) begin
      arp_mem[arp_wr_addr] <= arp_wr_mac;
    end
  end

  // Record fields stay put until the next pop, which waits for the handshake
  always_ff @(posedge mac_clk) begin
    fixed_sum <= fixed_fold[15:0] + 16'(fixed_fold[16]);
    if (rec_pop) begin
      hop_mac     <= arp_mem[arp_idx];
      hop_ip      <= rec_ip;
      hop_port    <= rec_port;
      hop_words   <= rec_words;
      hop_ip_len  <= (rec_words << 3) + len_w'(ip_hdr_bytes + udp_hdr_bytes);
      hop_udp_len <= (rec_words << 3) + len_w'(udp_hdr_bytes);
    end
    // Three fold stages of the ones' complement sum
    if (stage_vld[0]) begin
      csum_0 <= 18'(fixed_sum) + 18'(hop_ip_len) + 18'(hop_ip[31:16]) + 18'(hop_ip[15:0]);
    end
    if (stage_vld[1]) begin
      csum_1 <= 17'(csum_0[15:0]) + 17'(csum_0[17:16]);
    end
    if (stage_vld[2]) begin
      hop_csum <= ~(csum_1[15:0] + 16'(csum_1[16]));
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      stage_vld <= '0;
      hop_req   <= 1'b0;
      ack_wait  <= 1'b0;
    end else begin
      stage_vld <= {stage_vld[1:0], rec_pop};
      if (stage_vld[2]) begin
        hop_req <= 1'b1;
      end else if (hop_req && hop_ack) begin
        hop_req  <= 1'b0;
        ack_wait <= 1'b1;
      end
      // Free again once the framer has released ack
      if (ack_wait && !hop_ack) begin
        ack_wait <= 1'b0;
      end
    end
  end

endmodule

/* verilog/udp_tx_framer.sv */
`timescale 1ns/1ps

module udp_tx_framer (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           local_enable,
  input  logic [udp_net_pkg::mac_w-1:0]  local_mac,
  input  logic [udp_net_pkg::ip_w-1:0]   local_ip,
  input  logic [udp_net_pkg::port_w-1:0] local_port,
  input  logic                           hop_req,
  input  logic [udp_net_pkg::mac_w-1:0]  hop_mac,
  input  logic [udp_net_pkg::ip_w-1:0]   hop_ip,
  input  logic [udp_net_pkg::port_w-1:0] hop_port,
  input  logic [udp_tx_pkg::len_w-1:0]   hop_words,
  input  logic [udp_tx_pkg::len_w-1:0]   hop_ip_len,
  input  logic [udp_tx_pkg::len_w-1:0]   hop_udp_len,
  input  logic [15:0]                    hop_csum,
  input  logic [udp_tx_pkg::data_w-1:0]  pay_data,
  input  logic                           mac_tx_ack,
  output logic                           hop_ack,
  output logic                           pay_pop,
  output logic                           mac_tx_start,
  output logic [udp_tx_pkg::data_w-1:0]  mac_tx_data,
  output logic [7:0]                     mac_tx_data_valid
);
  import udp_net_pkg::*;
  import udp_tx_pkg::*;

  tx_state_t         state;
  logic              loaded;
  logic              take;
  logic              last_pay;
  logic [2:0]        hdr_cnt;
  logic [len_w-1:0]  pay_left;
  logic [15:0]       leftover;
  logic [mac_w-1:0]  dst_mac;
  logic [ip_w-1:0]   dst_ip;
  logic [port_w-1:0] dst_port;
  logic [len_w-1:0]  ip_len;
  logic [len_w-1:0]  udp_len;
  logic [15:0]       ip_csum;
  // Next MAC word with its first wire byte in the top bits
  logic [data_w-1:0] wire_word;

  // Wire order to lane order, byte 0 lands on bits 7:0
  function automatic logic [data_w-1:0] lane_order(input logic [data_w-1:0] be);
    logic [data_w-1:0] lanes;
    for (int i = 0; i < data_w / 8; i++) begin
      lanes[8*i +: 8] = be[data_w-1-8*i -: 8];
    end
    return lanes;
  endfunction

  assign take     = (state == tx_idle) && !loaded && hop_req && !hop_ack;
  assign last_pay = pay_left == len_w'(1);

  assign mac_tx_start = state == tx_start;
  assign pay_pop      = ((state == tx_first || state == tx_data) && !last_pay) ||
                        (state == tx_last);

  always_ff @(posedge mac_clk) begin
    if (take) begin
      dst_mac  <= hop_mac;
      dst_ip   <= hop_ip;
      dst_port <= hop_port;
      ip_len   <= hop_ip_len;
      udp_len  <= hop_udp_len;
      ip_csum  <= hop_csum;
    end
    // Last two bytes of each payload word go out in the next MAC word
    leftover <= pay_data[15:0];
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state    <= tx_idle;
      loaded   <= 1'b0;
      hop_ack  <= 1'b0;
      hdr_cnt  <= '0;
      pay_left <= '0;
    end else begin
      if (hop_ack && !hop_req) begin
        hop_ack <= 1'b0;
      end
      case (state)
        tx_idle: begin
          if (loaded && local_enable) begin
            loaded <= 1'b0;
            state  <= tx_start;
          end else if (take) begin
            loaded   <= 1'b1;
            hop_ack  <= 1'b1;
            pay_left <= hop_words;
          end
        end
        tx_start: begin
          // Word 1 is held until the MAC takes it
          if (mac_tx_ack) begin
            hdr_cnt <= 3'd2;
            state   <= tx_hdr;
          end
        end
        tx_hdr: begin
          if (hdr_cnt == 3'(hdr_words)) begin
            state <= tx_first;
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
        end
        tx_first, tx_data: begin
          if (last_pay) begin
            state <= tx_last;
          end else begin
            pay_left <= pay_left - 1'b1;
            state    <= tx_data;
          end
        end
        tx_last: begin
          state <= tx_idle;
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

  always_comb begin
    case (state)
      tx_start: wire_word = {dst_mac, local_mac[47:32]};
      tx_hdr: begin
        case (hdr_cnt)
          3'd2:    wire_word = {local_mac[31:0], eth_type_ipv4, ip_ver_ihl, 8'h00};
          3'd3:    wire_word = {ip_len, 16'h0000, ip_flags_frag, ip_ttl, ip_proto_udp};
          3'd4:    wire_word = {ip_csum, local_ip, dst_ip[31:16]};
          default: wire_word = {dst_ip[15:0], local_port, dst_port, udp_len};
        endcase
      end
      // Zero UDP checksum ahead of the first payload bytes
      tx_first: wire_word = {16'h0000, pay_data[63:16]};
      tx_data:  wire_word = {leftover, pay_data[63:16]};
      tx_last:  wire_word = {leftover, 48'h0};
      default:  wire_word = '0;
    endcase
  end

  assign mac_tx_data = lane_order(wire_word);

  always_comb begin
    case (state)
      tx_idle: mac_tx_data_valid = 8'h00;
      tx_last: mac_tx_data_valid = lane_last;
      default: mac_tx_data_valid = lane_all;
    endcase
  end

endmodule

/* verilog/udp_tx_top.sv */
`timescale 1ns/1ps

module udp_tx_top (
  input  logic                           mac_clk,
  input  logic                           app_rst,
  input  logic                           local_enable,
  input  logic [udp_net_pkg::mac_w-1:0]  local_mac,
  input  logic [udp_net_pkg::ip_w-1:0]   local_ip,
  input  logic [udp_net_pkg::port_w-1:0] local_port,
  input  logic [udp_tx_pkg::arp_aw-1:0]  local_gateway,
  input  logic                           arp_wr_en,
  input  logic [udp_tx_pkg::arp_aw-1:0]  arp_wr_addr,
  input  logic [udp_net_pkg::mac_w-1:0]  arp_wr_mac,
  input  logic                           app_tx_valid,
  input  logic                           app_tx_end_of_frame,
  input  logic [udp_tx_pkg::data_w-1:0]  app_tx_data,
  input  logic [udp_net_pkg::ip_w-1:0]   app_tx_dest_ip,
  input  logic [udp_net_pkg::port_w-1:0] app_tx_dest_port,
  output logic                           app_tx_afull,
  output logic                           app_tx_overflow,
  output logic                           mac_tx_start,
  output logic [udp_tx_pkg::data_w-1:0]  mac_tx_data,
  output logic [7:0]                     mac_tx_data_valid,
  input  logic                           mac_tx_ack
);
  import udp_net_pkg::*;
  import udp_tx_pkg::*;

  // Ingress to route and framer
  logic [data_w-1:0] pay_data;
  logic              pay_pop;
  logic [ip_w-1:0]   rec_ip;
  logic [port_w-1:0] rec_port;
  logic [len_w-1:0]  rec_words;
  logic              rec_empty;
  logic              rec_pop;

  // Route to framer
  logic              hop_req;
  logic              hop_ack;
  logic [mac_w-1:0]  hop_mac;
  logic [ip_w-1:0]   hop_ip;
  logic [port_w-1:0] hop_port;
  logic [len_w-1:0]  hop_words;
  logic [len_w-1:0]  hop_ip_len;
  logic [len_w-1:0]  hop_udp_len;
  logic [15:0]       hop_csum;

  udp_tx_ingress i_ingress (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .pay_pop             (pay_pop),
    .rec_pop             (rec_pop),
    .pay_data            (pay_data),
    .rec_ip              (rec_ip),
    .rec_port            (rec_port),
    .rec_words           (rec_words),
    .rec_empty           (rec_empty),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow)
  );

  udp_tx_route i_route (
    .mac_clk       (mac_clk),
    .app_rst       (app_rst),
    .local_ip      (local_ip),
    .local_gateway (local_gateway),
    .arp_wr_en     (arp_wr_en),
    .arp_wr_addr   (arp_wr_addr),
    .arp_wr_mac    (arp_wr_mac),
    .rec_ip        (rec_ip),
    .rec_port      (rec_port),
    .rec_words     (rec_words),
    .rec_empty     (rec_empty),
    .hop_ack       (hop_ack),
    .rec_pop       (rec_pop),
    .hop_req       (hop_req),
    .hop_mac       (hop_mac),
    .hop_ip        (hop_ip),
    .hop_port      (hop_port),
    .hop_words     (hop_words),
    .hop_ip_len    (hop_ip_len),
    .hop_udp_len   (hop_udp_len),
    .hop_csum      (hop_csum)
  );

  udp_tx_framer i_framer (
    .mac_clk           (mac_clk),
    .app_rst           (app_rst),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .hop_req           (hop_req),
    .hop_mac           (hop_mac),
    .hop_ip            (hop_ip),
    .hop_port          (hop_port),
    .hop_words         (hop_words),
    .hop_ip_len        (hop_ip_len),
    .hop_udp_len       (hop_udp_len),
    .hop_csum          (hop_csum),
    .pay_data          (pay_data),
    .mac_tx_ack        (mac_tx_ack),
    .hop_ack           (hop_ack),
    .pay_pop           (pay_pop),
    .mac_tx_start      (mac_tx_start),
    .mac_tx_data       (mac_tx_data),
    .mac_tx_data_valid (mac_tx_data_valid)
  );

endmodule

/* bench/udp_tx_tests.svh */
// LCG with the Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
  assert (got === exp) else begin
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    errors++;
  end
endtask

task automatic finish_test(input string name, input int err_before);
  tests_run++;
  if (errors == err_before) begin
    $display("%s: passed", name);
  end else begin
    tests_bad++;
    $display("%s: %0d errors", name, errors - err_before);
  end
endtask

task automatic apply_reset();
  @(negedge mac_clk);
  app_rst = 1'b1;
  repeat (5) @(negedge mac_clk);
  app_rst = 1'b0;
endtask

task automatic idle_app();
  @(negedge mac_clk);
  app_tx_valid = 1'b0;
  app_tx_end_of_frame = 1'b0;
endtask

task automatic clear_capture();
  cap_bytes.delete();
  exp_bytes.delete();
  frame_words.delete();
  exp_words.delete();
  frame_mask.delete();
endtask

task automatic arp_write(input logic [7:0] addr, input logic [47:0] mac);
  @(negedge mac_clk);
  arp_wr_en = 1'b1;
  arp_wr_addr = addr;
  arp_wr_mac = mac;
  arp_model[addr] = mac;
  @(negedge mac_clk);
  arp_wr_en = 1'b0;
endtask

// Low nbytes of v, most significant first
task automatic push_field(input logic [63:0] v, input int nbytes);
  for (int i = nbytes - 1; i >= 0; i--) begin
    exp_bytes.push_back(v[8*i +: 8]);
  end
endtask

// Reference frame for the payload now held in pay_words
task automatic expect_frame(input logic [31:0] dst_ip, input logic [15:0] dst_port);
  int          n;
  logic [15:0] ip_len;
  logic [15:0] udp_len;
  logic [15:0] csum;
  logic [31:0] sum;
  logic [47:0] dst_mac;
  n = pay_words.size();
  ip_len = 16'(8 * n + 28);
  udp_len = 16'(8 * n + 8);
  if (dst_ip[31:8] == local_ip[31:8]) begin
    dst_mac = arp_model[dst_ip[7:0]];
  end else begin
    dst_mac = arp_model[local_gateway];
  end
  // Ten header words, checksum field counted as zero
  sum = 32'h4500 + 32'(ip_len) + 32'h4000 + 32'hff11 + 32'(local_ip[31:16]) +
        32'(local_ip[15:0]) + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);
  sum = 32'(sum[15:0]) + 32'(sum[31:16]);
  sum = 32'(sum[15:0]) + 32'(sum[31:16]);
  csum = ~sum[15:0];
  push_field(64'(dst_mac), 6);
  push_field(64'(local_mac), 6);
  push_field(64'h0800_4500, 4);
  push_field({ip_len, 16'h0000, 16'h4000, 16'hff11}, 8);
  push_field(64'(csum), 2);
  push_field(64'(local_ip), 4);
  push_field(64'(dst_ip), 4);
  push_field({local_port, dst_port, udp_len, 16'h0000}, 8);
  foreach (pay_words[i]) begin
    push_field(pay_words[i], 8);
  end
  exp_words.push_back(n + 6);
endtask

// Leaves valid high on the last word so frames can follow back to back
task automatic send_frame(input logic [31:0] dst_ip, input logic [15:0] dst_port, input int n);
  logic [63:0] w;
  pay_words.delete();
  for (int i = 0; i < n; i++) begin
    pay_rng = lcg_next(pay_rng);
    w[63:32] = pay_rng;
    pay_rng = lcg_next(pay_rng);
    w[31:0] = pay_rng;
    pay_words.push_back(w);
    @(negedge mac_clk);
    app_tx_valid = 1'b1;
    app_tx_data = w;
    app_tx_end_of_frame = (i == n - 1);
    app_tx_dest_ip = dst_ip;
    app_tx_dest_port = dst_port;
  end
  expect_frame(dst_ip, dst_port);
endtask

// Payload words with no end of frame
task automatic push_words(input int n);
  repeat (n) begin
    @(negedge mac_clk);
    pay_rng = lcg_next(pay_rng);
    app_tx_valid = 1'b1;
    app_tx_data = {pay_rng, ~pay_rng};
    app_tx_end_of_frame = 1'b0;
  end
  idle_app();
endtask

task automatic check_frames(input int count);
  int n;
  while (frame_words.size() < count) begin
    @(negedge mac_clk);
  end
  check_value("captured byte count", cap_bytes.size(), exp_bytes.size());
  n = (cap_bytes.size() < exp_bytes.size()) ? cap_bytes.size() : exp_bytes.size();
  for (int i = 0; i < n; i++) begin
    check_value($sformatf("mac_tx_data byte %0d", i), cap_bytes[i], exp_bytes[i]);
  end
  for (int k = 0; k < count; k++) begin
    check_value($sformatf("frame %0d word count", k), frame_words[k], exp_words[k]);
    check_value($sformatf("frame %0d last mac_tx_data_valid", k), frame_mask[k], 8'h03);
  end
endtask

task automatic test_reset_state();
  int err0;
  err0 = errors;
  check_value("mac_tx_start", mac_tx_start, 0);
  check_value("mac_tx_data_valid", mac_tx_data_valid, 0);
  check_value("app_tx_afull", app_tx_afull, 0);
  check_value("app_tx_overflow", app_tx_overflow, 0);
  finish_test("reset_state", err0);
endtask

task automatic test_local_subnet();
  int err0;
  err0 = errors;
  clear_capture();
  arp_write(8'h37, 48'h0a1b_2c3d_4e5f);
  send_frame(32'hc0a8_0a37, 16'h2345, 3);
  idle_app();
  check_frames(1);
  finish_test("local_subnet", err0);
endtask

task automatic test_gateway();
  int err0;
  err0 = errors;
  clear_capture();
  // Entry at the low IP byte must not be used off the subnet
  arp_write(8'h09, 48'h6677_8899_aabb);
  arp_write(8'hfe, 48'h0200_5e00_00fe);
  send_frame(32'h0a00_0009, 16'h0035, 4);
  idle_app();
  check_frames(1);
  finish_test("gateway_route", err0);
endtask

task automatic test_back_to_back();
  int err0;
  err0 = errors;
  clear_capture();
  for (int f = 0; f < 4; f++) begin
    pay_rng = lcg_next(pay_rng);
    send_frame(f[0] ? 32'h0a00_0009 : 32'hc0a8_0a37, 16'(16'h4000 + f),
               1 + int'(pay_rng[23:16] % 20));
  end
  idle_app();
  check_frames(4);
  finish_test("back_to_back", err0);
endtask

task automatic test_enable_hold();
  int err0;
  err0 = errors;
  clear_capture();
  @(negedge mac_clk);
  local_enable = 1'b0;
  send_frame(32'hc0a8_0a37, 16'h5000, 2);
  send_frame(32'h0a00_0009, 16'h5001, 5);
  idle_app();
  repeat (60) begin
    @(negedge mac_clk);
    check_value("mac_tx_start", mac_tx_start, 0);
  end
  check_value("captured frame count", frame_words.size(), 0);
  local_enable = 1'b1;
  check_frames(2);
  finish_test("enable_hold", err0);
endtask

task automatic test_overflow();
  int err0;
  err0 = errors;
  @(negedge mac_clk);
  local_enable = 1'b0;
  push_words(239);
  check_value("app_tx_afull", app_tx_afull, 0);
  push_words(1);
  check_value("app_tx_afull", app_tx_afull, 1);
  push_words(16);
  check_value("app_tx_overflow", app_tx_overflow, 0);
  push_words(1);
  check_value("app_tx_overflow", app_tx_overflow, 1);
  repeat (20) @(negedge mac_clk);
  check_value("app_tx_overflow", app_tx_overflow, 1);
  apply_reset();
  check_value("app_tx_overflow", app_tx_overflow, 0);
  check_value("app_tx_afull", app_tx_afull, 0);
  local_enable = 1'b1;
  finish_test("overflow", err0);
endtask

/* bench/udp_tx_tb.sv */
`timescale 1ns/1ps

module udp_tx_tb;
  import udp_net_pkg::*;

  localparam int cycle_limit = 4000;

  logic              mac_clk;
  logic              app_rst;
  logic              local_enable;
  logic [mac_w-1:0]  local_mac;
  logic [ip_w-1:0]   local_ip;
  logic [port_w-1:0] local_port;
  logic [7:0]        local_gateway;
  logic              arp_wr_en;
  logic [7:0]        arp_wr_addr;
  logic [mac_w-1:0]  arp_wr_mac;
  logic              app_tx_valid;
  logic              app_tx_end_of_frame;
  logic [63:0]       app_tx_data;
  logic [ip_w-1:0]   app_tx_dest_ip;
  logic [port_w-1:0] app_tx_dest_port;
  logic              app_tx_afull;
  logic              app_tx_overflow;
  logic              mac_tx_start;
  logic [63:0]       mac_tx_data;
  logic [7:0]        mac_tx_data_valid;
  logic              mac_tx_ack = 1'b0;

  // MAC model state
  logic [31:0]       mac_rng = 32'd56849;
  int                ack_delay = 0;
  logic [7:0]        prev_valid = 8'h00;
  logic [7:0]        last_mask = 8'h00;
  int                cap_words = 0;

  // Captured and expected traffic
  logic [7:0]        cap_bytes[$];
  logic [7:0]        exp_bytes[$];
  int                frame_words[$];
  int                exp_words[$];
  logic [7:0]        frame_mask[$];
  logic [63:0]       pay_words[$];
  logic [mac_w-1:0]  arp_model[256];
  logic [31:0]       pay_rng;
  int                cycles;
  int                errors;
  int                tests_run;
  int                tests_bad;

  udp_tx_top i_dut (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .local_enable        (local_enable),
    .local_mac           (local_mac),
    .local_ip            (local_ip),
    .local_port          (local_port),
    .local_gateway       (local_gateway),
    .arp_wr_en           (arp_wr_en),
    .arp_wr_addr         (arp_wr_addr),
    .arp_wr_mac          (arp_wr_mac),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .mac_tx_start        (mac_tx_start),
    .mac_tx_data         (mac_tx_data),
    .mac_tx_data_valid   (mac_tx_data_valid),
    .mac_tx_ack          (mac_tx_ack)
  );

  `include "udp_tx_tests.svh"

  initial begin
    mac_clk = 1'b0;
    forever #2 mac_clk = ~mac_clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge mac_clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  // Valid lanes in wire order, byte 0 on bits 7:0
  task automatic capture_word();
    for (int i = 0; i < 8; i++) begin
      if (mac_tx_data_valid[i]) begin
        cap_bytes.push_back(mac_tx_data[8*i +: 8]);
      end
    end
    cap_words++;
    last_mask = mac_tx_data_valid;
  endtask

  // MAC model, acks start after a random wait and then takes a word per cycle
  always @(negedge mac_clk) begin
    if (app_rst) begin
      mac_tx_ack = 1'b0;
      prev_valid = 8'h00;
      cap_words = 0;
    end else begin
      if (mac_tx_start && !mac_tx_ack) begin
        if (ack_delay == 0) begin
          // Word 1 moves on the coming rising edge
          mac_tx_ack = 1'b1;
          capture_word();
        end else begin
          ack_delay--;
        end
      end else begin
        mac_tx_ack = 1'b0;
        if (mac_tx_data_valid != 8'h00) begin
          capture_word();
        end
      end
      // Frame ends when the valid mask drops back to zero
      if (mac_tx_data_valid == 8'h00 && prev_valid != 8'h00) begin
        frame_words.push_back(cap_words);
        frame_mask.push_back(last_mask);
        cap_words = 0;
        mac_rng = lcg_next(mac_rng);
        ack_delay = int'(mac_rng[26:24] % 3'd6);
      end
      prev_valid = mac_tx_data_valid;
    end
  end

  initial begin
    app_rst = 1'b1;
    local_enable = 1'b1;
    local_mac = 48'h0211_2233_4455;
    local_ip = 32'hc0a8_0a01;
    local_port = 16'h1f90;
    local_gateway = 8'hfe;
    arp_wr_en = 1'b0;
    arp_wr_addr = 8'h00;
    arp_wr_mac = '0;
    app_tx_valid = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data = '0;
    app_tx_dest_ip = '0;
    app_tx_dest_port = '0;
    pay_rng = 32'd56849;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    apply_reset();
    test_reset_state();
    test_local_subnet();
    test_gateway();
    test_back_to_back();
    test_enable_hold();
    test_overflow();
    $display("Summary: %0d tests, %0d with errors, %0d check errors",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
verilog/udp_net_pkg.sv
verilog/udp_tx_pkg.sv
verilog/udp_tx_ingress.sv
verilog/udp_tx_route.sv
verilog/udp_tx_framer.sv
verilog/udp_tx_top.sv
bench/udp_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UDP transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module udp_tx_tb -Mdir obj_dir -o udp_tx_sim -f compile.f

./obj_dir/udp_tx_sim > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "Simulation did not report a pass, see sim.log"
exit 1
